// File: src/lsu_pkg.sv
package lsu_pkg;

    // --------------------
    // Widths
    // --------------------

    localparam int LSU_ADDR_W = 32;
    localparam int LSU_DATA_W = 32;
    // One strobe bit per data byte
    localparam int LSU_STRB_W = LSU_DATA_W / 8;

    // --------------------
    // Funct3 codes
    // --------------------

    // Stores share FN_B, FN_H and FN_W with the signed loads
    localparam logic [2:0] FN_B  = 3'b000;
    localparam logic [2:0] FN_H  = 3'b001;
    localparam logic [2:0] FN_W  = 3'b010;
    localparam logic [2:0] FN_BU = 3'b100;
    localparam logic [2:0] FN_HU = 3'b101;

    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,
        KIND_LOAD  = 2'd1,
        KIND_STORE = 2'd2
    } lsu_kind_e;

    // AXI AxSIZE encoding of bytes per beat as a power of two
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } axi_size_e;

    // Width field is 00 byte, 01 half, 10 word in both views
    typedef union packed {
        struct packed {
            logic       is_unsigned;
            logic [1:0] width;
        } ld;
        struct packed {
            logic       rsvd;
            logic [1:0] width;
        } st;
    } lsu_funct_u;

    typedef struct packed {
        lsu_kind_e             kind;
        lsu_funct_u            funct;
        logic [LSU_ADDR_W-1:0] addr;
        logic [LSU_DATA_W-1:0] wdata;
    } lsu_req_t;

    // Shared by AW and AR
    typedef struct packed {
        logic [LSU_ADDR_W-1:0] addr;
        axi_size_e             size;
    } axi_addr_t;

    typedef struct packed {
        logic [LSU_DATA_W-1:0] data;
        logic [LSU_STRB_W-1:0] strb;
    } axi_wdata_t;

endpackage

// File: src/lsu_ctrl.sv
`timescale 1ns/10ps

module lsu_ctrl
(
    input  logic              M_AXI_ACLK,
    input  logic              M_AXI_ARESETN,
    input  logic              i_start,
    input  lsu_pkg::lsu_req_t i_req,
    input  logic              i_wr_end,
    input  logic              i_rd_end,
    output logic              o_wr_go,
    output logic              o_rd_go,
    output lsu_pkg::lsu_req_t o_held,
    output logic              o_busy,
    output logic              o_done
);
    import lsu_pkg::*;

    lsu_req_t req_q;
    logic     busy_q;
    logic     done_q;
    logic     wr_go_q;
    logic     rd_go_q;
    logic     accept;
    logic     start_wr;
    logic     start_rd;
    logic     start_pass;

    // A start seen while busy is dropped
    assign accept = i_start && !busy_q;

    // Decode the request kind into one start
    always_comb
    begin
        start_wr   = 1'b0;
        start_rd   = 1'b0;
        start_pass = 1'b0;
        if (accept)
        begin
            case (i_req.kind)
                KIND_LOAD:  start_rd   = 1'b1;
                KIND_STORE: start_wr   = 1'b1;
                KIND_NONE:  start_pass = 1'b1;
                default:    start_pass = 1'b1;
            endcase
        end
    end

    // Request stays put for the whole transfer
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (accept)
            req_q <= i_req;
    end

    // --------------------
    // Busy level and completion
    // --------------------

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            wr_go_q <= 1'b0;
            rd_go_q <= 1'b0;
            done_q  <= 1'b0;
            busy_q  <= 1'b0;
        end
        else
        begin
            wr_go_q <= start_wr;
            rd_go_q <= start_rd;
            // Pass-through ops finish one cycle after start
            done_q  <= start_pass || i_wr_end || i_rd_end;
            // Busy drops on the edge that ends the done pulse
            if (done_q)
                busy_q <= 1'b0;
            else if (accept)
                busy_q <= 1'b1;
        end
    end

    assign o_held  = req_q;
    assign o_busy  = busy_q;
    assign o_done  = done_q;
    assign o_wr_go = wr_go_q;
    assign o_rd_go = rd_go_q;

endmodule

// File: src/lsu_axi_wr.sv
`timescale 1ns/10ps

module lsu_axi_wr
(
    input  logic                M_AXI_ACLK,
    input  logic                M_AXI_ARESETN,
    input  logic                i_go,
    input  lsu_pkg::lsu_req_t   i_held,
    // AW channel
    output lsu_pkg::axi_addr_t  o_aw,
    output logic                o_awvalid,
    input  logic                i_awready,
    // W channel
    output lsu_pkg::axi_wdata_t o_w,
    output logic                o_wvalid,
    input  logic                i_wready,
    // B channel
    input  logic                i_bvalid,
    output logic                o_bready,
    output logic                o_end
);
    import lsu_pkg::*;

    axi_size_e             size;
    logic [LSU_STRB_W-1:0] base_strb;
    logic [1:0]            offset;
    logic                  awvalid_q;
    logic                  wvalid_q;
    logic                  bready_q;
    logic                  end_q;

    assign offset = i_held.addr[1:0];

    // Size and unshifted strobe from the store width
    always_comb
    begin
        case (i_held.funct.st.width)
            2'b00:
            begin
                size      = SIZE_BYTE;
                base_strb = 4'b0001;
            end
            2'b01:
            begin
                size      = SIZE_HALF;
                base_strb = 4'b0011;
            end
            default:
            begin
                size      = SIZE_WORD;
                base_strb = 4'b1111;
            end
        endcase
    end

    // Payload lanes follow the held request
    always_comb
    begin
        o_aw.addr = i_held.addr;
        o_aw.size = size;
        o_w.data  = i_held.wdata << {offset, 3'b000};
        o_w.strb  = base_strb << offset;
    end

    // --------------------
    // Handshakes
    // --------------------

    // AW and W complete independently of each other
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
        end
        else
        begin
            if (i_go)
                awvalid_q <= 1'b1;
            else if (awvalid_q && i_awready)
                awvalid_q <= 1'b0;

            if (i_go)
                wvalid_q <= 1'b1;
            else if (wvalid_q && i_wready)
                wvalid_q <= 1'b0;
        end
    end

    // BREADY is a single-cycle answer to BVALID
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            bready_q <= 1'b0;
            end_q    <= 1'b0;
        end
        else
        begin
            bready_q <= i_bvalid && !bready_q;
            end_q    <= bready_q && i_bvalid;
        end
    end

    assign o_awvalid = awvalid_q;
    assign o_wvalid  = wvalid_q;
    assign o_bready  = bready_q;
    assign o_end     = end_q;

endmodule

// File: src/lsu_axi_rd.sv
`timescale 1ns/10ps

module lsu_axi_rd
(
    input  logic                           M_AXI_ACLK,
    input  logic                           M_AXI_ARESETN,
    input  logic                           i_go,
    input  lsu_pkg::lsu_req_t              i_held,
    // AR channel
    output lsu_pkg::axi_addr_t             o_ar,
    output logic                           o_arvalid,
    input  logic                           i_arready,
    // R channel
    input  logic [lsu_pkg::LSU_DATA_W-1:0] i_rdata,
    input  logic                           i_rvalid,
    output logic                           o_rready,
    // To the load extender
    output logic [lsu_pkg::LSU_DATA_W-1:0] o_word,
    output logic                           o_capture,
    output logic                           o_end
);
    import lsu_pkg::*;

    axi_size_e             size;
    logic                  arvalid_q;
    logic                  rready_q;
    logic                  capture_q;
    logic                  end_q;
    logic [LSU_DATA_W-1:0] word_q;
    logic                  take;

    // Signed and unsigned loads of one width share a size
    always_comb
    begin
        case (i_held.funct.ld.width)
            2'b00:   size = SIZE_BYTE;
            2'b01:   size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
        o_ar.addr = i_held.addr;
        o_ar.size = size;
    end

    // First RVALID seen while RREADY is low
    assign take = i_rvalid && !rready_q;

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
            capture_q <= 1'b0;
            end_q     <= 1'b0;
        end
        else
        begin
            if (i_go)
                arvalid_q <= 1'b1;
            else if (arvalid_q && i_arready)
                arvalid_q <= 1'b0;
            rready_q  <= take;
            capture_q <= take;
            end_q     <= capture_q;
        end
    end

    // Read word is taken on the RREADY rising edge
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (take)
            word_q <= i_rdata;
    end

    assign o_arvalid = arvalid_q;
    assign o_rready  = rready_q;
    assign o_word    = word_q;
    assign o_capture = capture_q;
    assign o_end     = end_q;

endmodule

// File: src/lsu_load_ext.sv
`timescale 1ns/10ps

module lsu_load_ext
(
    input  logic                           M_AXI_ACLK,
    input  logic                           M_AXI_ARESETN,
    input  logic                           i_capture,
    input  logic [lsu_pkg::LSU_DATA_W-1:0] i_word,
    input  lsu_pkg::lsu_req_t              i_held,
    output logic [lsu_pkg::LSU_DATA_W-1:0] o_rdata
);
    import lsu_pkg::*;

    logic [LSU_DATA_W-1:0] shifted;
    logic [LSU_DATA_W-1:0] ext;
    logic [LSU_DATA_W-1:0] rdata_q;

    // Addressed byte moves down to lane 0
    assign shifted = i_word >> {i_held.addr[1:0], 3'b000};

    // --------------------
    // Extension
    // --------------------

    always_comb
    begin
        case ({i_held.funct.ld.is_unsigned, i_held.funct.ld.width})
            FN_B:    ext = {{24{shifted[7]}}, shifted[7:0]};
            FN_H:    ext = {{16{shifted[15]}}, shifted[15:0]};
            FN_W:    ext = shifted;
            FN_BU:   ext = {24'b0, shifted[7:0]};
            FN_HU:   ext = {16'b0, shifted[15:0]};
            default: ext = '0;
        endcase
    end

    // Result holds until the next load captures
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            rdata_q <= '0;
        else if (i_capture)
            rdata_q <= ext;
    end

    assign o_rdata = rdata_q;

endmodule

// File: src/lsu_top.sv
`timescale 1ns/10ps

module lsu_top
(
    input  logic                         M_AXI_ACLK,
    input  logic                         M_AXI_ARESETN,
    // Request side
    input  logic                         i_start,
    input  lsu_pkg::lsu_req_t            i_req,
    output logic                         o_busy,
    output logic                         o_done,
    output logic [lsu_pkg::LSU_DATA_W-1:0] o_rdata,
    // AW channel
    output lsu_pkg::axi_addr_t           o_aw,
    output logic                         o_awvalid,
    input  logic                         i_awready,
    // W channel
    output lsu_pkg::axi_wdata_t          o_w,
    output logic                         o_wvalid,
    output logic                         o_wlast,
    input  logic                         i_wready,
    // B channel
    input  logic                         i_bvalid,
    output logic                         o_bready,
    // AR channel
    output lsu_pkg::axi_addr_t           o_ar,
    output logic                         o_arvalid,
    input  logic                         i_arready,
    // R channel
    input  logic [lsu_pkg::LSU_DATA_W-1:0] i_rdata,
    input  logic                         i_rvalid,
    output logic                         o_rready
);
    import lsu_pkg::*;

    lsu_req_t              held;
    logic                  wr_go;
    logic                  rd_go;
    logic                  wr_end;
    logic                  rd_end;
    logic [LSU_DATA_W-1:0] rd_word;
    logic                  rd_capture;

    // Every transfer is a single beat
    assign o_wlast = 1'b1;

    lsu_ctrl u_ctrl (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_start       (i_start),
        .i_req         (i_req),
        .i_wr_end      (wr_end),
        .i_rd_end      (rd_end),
        .o_wr_go       (wr_go),
        .o_rd_go       (rd_go),
        .o_held        (held),
        .o_busy        (o_busy),
        .o_done        (o_done)
    );

    lsu_axi_wr u_axi_wr (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_go          (wr_go),
        .i_held        (held),
        .o_aw          (o_aw),
        .o_awvalid     (o_awvalid),
        .i_awready     (i_awready),
        .o_w           (o_w),
        .o_wvalid      (o_wvalid),
        .i_wready      (i_wready),
        .i_bvalid      (i_bvalid),
        .o_bready      (o_bready),
        .o_end         (wr_end)
    );

    lsu_axi_rd u_axi_rd (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_go          (rd_go),
        .i_held        (held),
        .o_ar          (o_ar),
        .o_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_rdata       (i_rdata),
        .i_rvalid      (i_rvalid),
        .o_rready      (o_rready),
        .o_word        (rd_word),
        .o_capture     (rd_capture),
        .o_end         (rd_end)
    );

    lsu_load_ext u_load_ext (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_capture     (rd_capture),
        .i_word        (rd_word),
        .i_held        (held),
        .o_rdata       (o_rdata)
    );

endmodule

// File: sim/lsu_props.sv
`timescale 1ns/10ps

module lsu_props
(
    input logic M_AXI_ACLK,
    input logic M_AXI_ARESETN,
    input logic i_awvalid,
    input logic i_awready,
    input logic i_wvalid,
    input logic i_wready,
    input logic i_arvalid,
    input logic i_arready,
    input logic i_rready,
    input logic i_bready,
    input logic i_done,
    input logic i_busy
);

    // --------------------
    // VALID stability
    // --------------------

    aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_awvalid && !i_awready |=> i_awvalid)
        else $error("AWVALID dropped before AWREADY");

    w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_wvalid && !i_wready |=> i_wvalid)
        else $error("WVALID dropped before WREADY");

    ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_arvalid && !i_arready |=> i_arvalid)
        else $error("ARVALID dropped before ARREADY");

    // --------------------
    // Pulses and exclusion
    // --------------------

    rready_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_rready |=> !i_rready)
        else $error("RREADY high for more than one cycle");

    bready_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_bready |=> !i_bready)
        else $error("BREADY high for more than one cycle");

    // One transfer in flight at a time
    aw_ar_excl: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        !(i_awvalid && i_arvalid))
        else $error("AWVALID and ARVALID high together");

    done_busy: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_done |-> i_busy)
        else $error("o_done without o_busy");

endmodule

bind lsu_top lsu_props u_props (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .i_awvalid     (o_awvalid),
    .i_awready     (i_awready),
    .i_wvalid      (o_wvalid),
    .i_wready      (i_wready),
    .i_arvalid     (o_arvalid),
    .i_arready     (i_arready),
    .i_rready      (o_rready),
    .i_bready      (o_bready),
    .i_done        (o_done),
    .i_busy        (o_busy)
);

// File: sim/tb_lsu.sv
`timescale 1ns/10ps

module tb_lsu;
    import lsu_pkg::*;

    localparam int MAX_REQ = 48;
    localparam int FIELDS  = 5;

    logic                  M_AXI_ACLK;
    logic                  M_AXI_ARESETN;
    logic                  i_start;
    lsu_req_t              i_req;
    logic                  o_busy;
    logic                  o_done;
    logic [LSU_DATA_W-1:0] o_rdata;
    axi_addr_t             o_aw;
    logic                  o_awvalid;
    logic                  i_awready;
    axi_wdata_t            o_w;
    logic                  o_wvalid;
    logic                  o_wlast;
    logic                  i_wready;
    logic                  i_bvalid;
    logic                  o_bready;
    axi_addr_t             o_ar;
    logic                  o_arvalid;
    logic                  i_arready;
    logic [LSU_DATA_W-1:0] i_rdata;
    logic                  i_rvalid;
    logic                  o_rready;

    // Five words per request in file column order
    logic [31:0] stim [0:FIELDS*MAX_REQ-1];
    logic [7:0]  mem [0:255];
    logic [31:0] seed;
    logic [2:0]  cur_funct;
    logic [31:0] cur_addr;
    logic [31:0] cur_wdata;
    logic [31:0] last_load;
    int          n_req;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          done_count = 0;

    lsu_top dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Slave delay of 0 to 3 cycles
    function automatic int next_delay();
        seed = xorshift32(seed);
        return int'(seed[1:0]);
    endfunction

    // Lanes from the offset up to offset plus the access size in bytes
    function automatic logic [3:0] expected_strobe(input logic [2:0] funct3,
                                                   input logic [1:0] offset);
        logic [3:0] strb;
        int         nbytes;
        int         k;
        nbytes = 1 << funct3[1:0];
        strb   = '0;
        for (k = 0; k < 4; k++)
            strb[k] = (k >= offset) && (k < offset + nbytes);
        return strb;
    endfunction

    // Byte n of the store data lands on lane n plus the offset
    function automatic logic [31:0] expected_wdata(input logic [31:0] wdata,
                                                   input logic [1:0]  offset);
        logic [31:0] data;
        int          k;
        data = '0;
        for (k = offset; k < 4; k++)
            data[8*k +: 8] = wdata[8*(k-offset) +: 8];
        return data;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at time %0d ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "first mismatch ends the run");
    endtask

    // Raises a flag once its delay has run out
    task automatic count_down(inout int dly, inout logic flag);
        if (dly == 0)
            flag = 1'b1;
        else
            dly--;
    endtask

    initial
    begin
        M_AXI_ACLK = 1'b0;
        forever
            #5 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    always @(posedge M_AXI_ACLK)
    begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("Timeout: requests did not complete within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    always @(negedge M_AXI_ACLK)
    begin
        if (o_done)
            done_count <= done_count + 1;
    end

    // --------------------
    // AXI slave memory model
    // --------------------

    initial
    begin
        logic        rst_s;
        logic        aw_hs;
        logic        w_hs;
        logic        ar_hs;
        logic        b_hs;
        logic        r_hs;
        logic        aw_req;
        logic        w_req;
        logic        ar_req;
        logic        aw_got;
        logic        w_got;
        logic        b_pend;
        logic        r_pend;
        logic        wlast_s;
        axi_addr_t   aw_s;
        axi_addr_t   ar_s;
        axi_addr_t   awl;
        axi_addr_t   arl;
        axi_wdata_t  w_s;
        axi_wdata_t  wl;
        logic [3:0]  exp_strb;
        logic [31:0] exp_data;
        logic [31:0] mask;
        int          aw_dly;
        int          w_dly;
        int          ar_dly;
        int          b_dly;
        int          r_dly;
        int          idx;
        seed      = 32'h9c03;
        i_awready = 1'b0;
        i_wready  = 1'b0;
        i_arready = 1'b0;
        i_bvalid  = 1'b0;
        i_rvalid  = 1'b0;
        i_rdata   = '0;
        aw_got    = 1'b0;
        w_got     = 1'b0;
        b_pend    = 1'b0;
        r_pend    = 1'b0;
        aw_dly    = next_delay();
        w_dly     = next_delay();
        ar_dly    = next_delay();
        b_dly     = next_delay();
        r_dly     = next_delay();
        for (idx = 0; idx < 256; idx++)
            mem[idx] = 8'(idx) ^ 8'hc0;
        forever
        begin
            // Sample mid-cycle and act just after the next edge
            @(negedge M_AXI_ACLK);
            rst_s   = M_AXI_ARESETN;
            aw_hs   = o_awvalid && i_awready;
            aw_req  = o_awvalid && !i_awready;
            w_hs    = o_wvalid && i_wready;
            w_req   = o_wvalid && !i_wready;
            ar_hs   = o_arvalid && i_arready;
            ar_req  = o_arvalid && !i_arready;
            b_hs    = i_bvalid && o_bready;
            r_hs    = i_rvalid && o_rready;
            aw_s    = o_aw;
            w_s     = o_w;
            wlast_s = o_wlast;
            ar_s    = o_ar;
            @(posedge M_AXI_ACLK);
            #1;
            if (!rst_s)
            begin
                i_awready = 1'b0;
                i_wready  = 1'b0;
                i_arready = 1'b0;
                i_bvalid  = 1'b0;
                i_rvalid  = 1'b0;
                aw_got    = 1'b0;
                w_got     = 1'b0;
                b_pend    = 1'b0;
                r_pend    = 1'b0;
            end
            else
            begin
                if (aw_hs)
                begin
                    i_awready = 1'b0;
                    aw_got    = 1'b1;
                    awl       = aw_s;
                    aw_dly    = next_delay();
                    assert (aw_s.addr == cur_addr &&
                            aw_s.size == axi_size_e'({1'b0, cur_funct[1:0]}))
                    else
                        report_mismatch($sformatf("AW addr %h size %0d", aw_s.addr, aw_s.size));
                end
                else if (aw_req)
                    count_down(aw_dly, i_awready);

                if (w_hs)
                begin
                    i_wready = 1'b0;
                    w_got    = 1'b1;
                    wl       = w_s;
                    w_dly    = next_delay();
                    exp_strb = expected_strobe(cur_funct, cur_addr[1:0]);
                    exp_data = expected_wdata(cur_wdata, cur_addr[1:0]);
                    mask     = lane_mask(exp_strb);
                    assert (wlast_s)
                    else
                        report_mismatch("WLAST low on a single-beat write");
                    assert (w_s.strb == exp_strb)
                    else
                        report_mismatch($sformatf("WSTRB %b, expected %b", w_s.strb, exp_strb));
                    assert ((w_s.data & mask) == (exp_data & mask))
                    else
                        report_mismatch($sformatf("WDATA %h, expected %h under strobe %b",
                                                  w_s.data, exp_data, exp_strb));
                end
                else if (w_req)
                    count_down(w_dly, i_wready);

                if (aw_got && w_got)
                begin
                    for (idx = 0; idx < 4; idx++)
                        if (wl.strb[idx])
                            mem[{awl.addr[7:2], 2'(idx)}] = wl.data[8*idx +: 8];
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                    b_pend = 1'b1;
                    b_dly  = next_delay();
                end

                if (b_hs)
                begin
                    i_bvalid = 1'b0;
                    b_pend   = 1'b0;
                end
                else if (b_pend && !i_bvalid)
                    count_down(b_dly, i_bvalid);

                if (ar_hs)
                begin
                    i_arready = 1'b0;
                    arl       = ar_s;
                    r_pend    = 1'b1;
                    r_dly     = next_delay();
                    ar_dly    = next_delay();
                    assert (ar_s.addr == cur_addr &&
                            ar_s.size == axi_size_e'({1'b0, cur_funct[1:0]}))
                    else
                        report_mismatch($sformatf("AR addr %h size %0d", ar_s.addr, ar_s.size));
                end
                else if (ar_req)
                    count_down(ar_dly, i_arready);

                if (r_hs)
                begin
                    i_rvalid = 1'b0;
                    r_pend   = 1'b0;
                end
                else if (r_pend && !i_rvalid)
                begin
                    i_rdata = {mem[{arl.addr[7:2], 2'd3}], mem[{arl.addr[7:2], 2'd2}],
                               mem[{arl.addr[7:2], 2'd1}], mem[{arl.addr[7:2], 2'd0}]};
                    count_down(r_dly, i_rvalid);
                end
            end
        end
    end

    // --------------------
    // Request sequencing
    // --------------------

    task automatic run_request(input int r);
        int          b;
        int          wait_cycles;
        logic        done_seen;
        lsu_kind_e   kind;
        logic [31:0] exp;
        b    = FIELDS * r;
        kind = lsu_kind_e'(stim[b][1:0]);
        exp  = stim[b+4];
        @(posedge M_AXI_ACLK);
        #1;
        cur_funct = stim[b+1][2:0];
        cur_addr  = stim[b+2];
        cur_wdata = stim[b+3];
        i_req     = {kind, cur_funct, cur_addr, cur_wdata};
        i_start   = 1'b1;
        @(posedge M_AXI_ACLK);
        #1;
        i_start     = 1'b0;
        wait_cycles = 0;
        done_seen   = 1'b0;
        while (!done_seen)
        begin
            @(negedge M_AXI_ACLK);
            wait_cycles++;
            assert (o_busy)
            else
                report_mismatch($sformatf("request %0d: o_busy low before o_done", r));
            done_seen = o_done;
        end
        assert (!(o_awvalid || o_wvalid || o_arvalid))
        else
            report_mismatch($sformatf("request %0d: a VALID is high at o_done", r));
        if (kind == KIND_LOAD)
        begin
            assert (o_rdata == exp)
            else
                report_mismatch($sformatf("request %0d: o_rdata %h, expected %h",
                                          r, o_rdata, exp));
            last_load = exp;
        end
        else
        begin
            assert (o_rdata == last_load)
            else
                report_mismatch($sformatf("request %0d: o_rdata %h changed from %h",
                                          r, o_rdata, last_load));
        end
        if (kind == KIND_NONE)
        begin
            assert (wait_cycles == 1)
            else
                report_mismatch($sformatf("request %0d: pass-through took %0d cycles",
                                          r, wait_cycles));
        end
        @(negedge M_AXI_ACLK);
        assert (!o_done && !o_busy && !(o_awvalid || o_wvalid || o_arvalid))
        else
            report_mismatch($sformatf("request %0d: o_done, o_busy or a VALID still high", r));
        assert (done_count == r + 1)
        else
            report_mismatch($sformatf("request %0d: %0d done pulses seen", r, done_count));
    endtask

    initial
    begin
        int k;
        M_AXI_ARESETN = 1'b0;
        i_start       = 1'b0;
        i_req         = '0;
        last_load     = '0;
        for (k = 0; k < FIELDS * MAX_REQ; k++)
            stim[k] = '1;
        $readmemh("sim/lsu_input.txt", stim);
        n_req = 0;
        while (n_req < MAX_REQ && stim[FIELDS*n_req] != '1)
            n_req++;
        if (n_req == 0)
        begin
            $display("No requests could be read from sim/lsu_input.txt");
            $display("Test failed");
            $fatal(1, "empty stimulus");
        end
        cycle_limit = 40 * n_req + 100;
        repeat (8) @(posedge M_AXI_ACLK);
        #1;
        M_AXI_ARESETN = 1'b1;
        for (k = 0; k < n_req; k++)
            run_request(k);
        $display("Test passed");
        $finish;
    end

endmodule

// File: sim/lsu_input.txt
// kind funct3 address wdata expected (kind 0 pass-through, 1 load, 2 store)
// expected is the load result, memory byte at a starts as a ^ c0
0 0 00000000 00000000 00000000
1 0 00000010 00000000 ffffffd0
1 0 00000011 00000000 ffffffd1
1 0 00000012 00000000 ffffffd2
1 0 00000013 00000000 ffffffd3
1 4 00000010 00000000 000000d0
1 4 00000011 00000000 000000d1
1 4 00000012 00000000 000000d2
1 4 00000013 00000000 000000d3
1 1 00000010 00000000 ffffd1d0
1 1 00000012 00000000 ffffd3d2
1 5 00000010 00000000 0000d1d0
1 5 00000012 00000000 0000d3d2
1 2 00000010 00000000 d3d2d1d0
0 3 00000040 12345678 00000000
1 0 00000085 00000000 00000045
1 1 00000086 00000000 00004746
1 2 00000084 00000000 47464544
1 4 00000087 00000000 00000047
2 0 00000020 000000aa 00000000
1 2 00000020 00000000 e3e2e1aa
2 0 00000021 123456bb 00000000
1 2 00000020 00000000 e3e2bbaa
2 0 00000022 ffffffcc 00000000
1 2 00000020 00000000 e3ccbbaa
2 0 00000023 000000dd 00000000
1 2 00000020 00000000 ddccbbaa
1 0 00000023 00000000 ffffffdd
1 4 00000021 00000000 000000bb
0 0 00000000 00000000 00000000
2 1 00000024 0000beef 00000000
1 2 00000024 00000000 e7e6beef
2 1 00000026 abcd1234 00000000
1 2 00000024 00000000 1234beef
1 1 00000026 00000000 00001234
1 5 00000024 00000000 0000beef
1 1 00000024 00000000 ffffbeef
2 2 00000028 80706050 00000000
1 2 00000028 00000000 80706050
1 0 0000002b 00000000 ffffff80
1 4 0000002a 00000000 00000070
0 0 00000000 00000000 00000000

// File: sources.f
src/lsu_pkg.sv
src/lsu_ctrl.sv
src/lsu_axi_wr.sv
src/lsu_axi_rd.sv
src/lsu_load_ext.sv
src/lsu_top.sv
sim/lsu_props.sv
sim/tb_lsu.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_lsu -f sources.f -o tb_lsu \
    && ./obj_dir/tb_lsu > sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
